// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen           = 32; // Data and address width
    localparam int reg_addr_width = 5;  // 32 architectural registers
    localparam int opcode_width   = 7;
    localparam int funct3_width   = 3;
    localparam int funct7_width   = 7;
    localparam int shamt_width    = 5;  // Enough to shift across xlen

    // RV32I major opcodes
    typedef enum logic [opcode_width-1:0] {
        op     = 7'b0110011, // Register-register ALU
        op_imm = 7'b0010011, // Register-immediate ALU
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111
    } opcode_e;

    // Branch conditions carried in funct3
    typedef enum logic [funct3_width-1:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100, // Signed
        bge  = 3'b101, // Signed
        bltu = 3'b110,
        bgeu = 3'b111
    } funct3_e;

    // Fields that the format does not carry are left at zero
    typedef struct packed {
        opcode_e                   opcode;
        logic [reg_addr_width-1:0] rd;
        logic [funct3_width-1:0]   funct3;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [funct7_width-1:0]   funct7;
        logic [shamt_width-1:0]    shamt;  // Immediate shifts only
        logic [xlen-1:0]           imm;    // Already sign-extended or shifted up
    } decoded_insn_t;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    typedef logic [rv_isa_pkg::xlen-1:0] word_t;

    localparam word_t reset_pc = 32'h0100_0000; // First fetch address
    localparam word_t pc_step  = 32'd4;         // One instruction word

    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        and_op = 4'd2,
        or_op  = 4'd3,
        xor_op = 4'd4,
        sll    = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        slt    = 4'd8,
        sltu   = 4'd9,
        pass_b = 4'd10 // Operand b straight through, used by LUI
    } alu_op_e;

    typedef struct packed {
        logic                                enable;
        logic [rv_isa_pkg::reg_addr_width-1:0] dest;
        word_t                               data;
    } rf_write_t;

    // Execute stage view for the testbench
    typedef struct packed {
        word_t pc;
        word_t alu_res;
        logic  br_taken;
    } exec_probe_t;

endpackage

// ==== decode/insn_decode.sv ====
module insn_decode (
    input  core_pkg::word_t           insn,
    output rv_isa_pkg::decoded_insn_t decoded
);

    rv_isa_pkg::opcode_e opcode;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_s;
    core_pkg::word_t     imm_b;
    core_pkg::word_t     imm_j;
    core_pkg::word_t     imm_u;

    assign opcode = rv_isa_pkg::opcode_e'(insn[6:0]);

    // Immediates for every format, the case below picks one
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_u = {insn[31:12], 12'b0}; // Upper 20 bits, low 12 cleared

    always_comb begin
        decoded = '0;
        case (opcode)
            rv_isa_pkg::op: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                decoded.rs2    = insn[24:20];
                decoded.funct7 = insn[31:25];
            end
            rv_isa_pkg::op_imm: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                // SLLI, SRLI and SRAI carry shamt and funct7 in the immediate slot
                if (insn[14:12] == 3'b001 || insn[14:12] == 3'b101) begin
                    decoded.shamt  = insn[24:20];
                    decoded.funct7 = insn[31:25];
                end else begin
                    decoded.imm = imm_i;
                end
            end
            rv_isa_pkg::load: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                decoded.imm    = imm_i;
            end
            rv_isa_pkg::store: begin
                decoded.opcode = opcode;
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                decoded.rs2    = insn[24:20];
                decoded.imm    = imm_s;
            end
            rv_isa_pkg::branch: begin
                decoded.opcode = opcode;
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                decoded.rs2    = insn[24:20];
                decoded.imm    = imm_b;
            end
            rv_isa_pkg::jal: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.imm    = imm_j;
            end
            rv_isa_pkg::jalr: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.funct3 = insn[14:12];
                decoded.rs1    = insn[19:15];
                decoded.imm    = imm_i;
            end
            rv_isa_pkg::lui, rv_isa_pkg::auipc: begin
                decoded.opcode = opcode;
                decoded.rd     = insn[11:7];
                decoded.imm    = imm_u;
            end
            default: ; // Unknown opcode, all fields stay zero
        endcase
    end

endmodule

// ==== execute/alu.sv ====
module alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result
);

    logic [rv_isa_pkg::shamt_width-1:0] shamt;

    assign shamt = b[rv_isa_pkg::shamt_width-1:0]; // Upper bits of b are ignored

    always_comb begin
        case (op)
            core_pkg::add:    result = a + b;
            core_pkg::sub:    result = a - b;
            core_pkg::and_op: result = a & b;
            core_pkg::or_op:  result = a | b;
            core_pkg::xor_op: result = a ^ b;
            core_pkg::sll:    result = a << shamt;
            core_pkg::srl:    result = a >> shamt;
            core_pkg::sra:    result = $signed(a) >>> shamt; // Sign bit fills
            core_pkg::slt:    result = core_pkg::word_t'($signed(a) < $signed(b));
            core_pkg::sltu:   result = core_pkg::word_t'(a < b);
            core_pkg::pass_b: result = b;
            default:          result = '0;
        endcase
    end

endmodule

// ==== execute/exec_control.sv ====
module exec_control (
    input  rv_isa_pkg::decoded_insn_t decoded,
    input  core_pkg::word_t           pc,
    input  core_pkg::word_t           rs1_data,
    input  core_pkg::word_t           rs2_data,
    input  core_pkg::word_t           alu_result,
    output core_pkg::alu_op_e         alu_op,
    output core_pkg::word_t           alu_a,
    output core_pkg::word_t           alu_b,
    output core_pkg::rf_write_t       rf_write,
    output core_pkg::exec_probe_t     probe
);

    core_pkg::word_t link_addr;
    logic            branch_cond;

    assign link_addr = pc + core_pkg::pc_step; // Return address of JAL and JALR

    // Condition by funct3, only used when the opcode is a branch
    always_comb begin
        case (rv_isa_pkg::funct3_e'(decoded.funct3))
            rv_isa_pkg::beq:  branch_cond = (rs1_data == rs2_data);
            rv_isa_pkg::bne:  branch_cond = (rs1_data != rs2_data);
            rv_isa_pkg::blt:  branch_cond = ($signed(rs1_data) < $signed(rs2_data));
            rv_isa_pkg::bge:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data));
            rv_isa_pkg::bltu: branch_cond = (rs1_data < rs2_data);
            rv_isa_pkg::bgeu: branch_cond = (rs1_data >= rs2_data);
            default:          branch_cond = 1'b0; // Reserved funct3 never branches
        endcase
    end

    always_comb begin
        alu_op          = core_pkg::add; // rs1 plus rs2 unless overridden
        alu_a           = rs1_data;
        alu_b           = rs2_data;
        rf_write.enable = 1'b0;
        rf_write.dest   = decoded.rd;
        rf_write.data   = alu_result;
        probe.pc        = pc;
        probe.alu_res   = alu_result;
        probe.br_taken  = 1'b0;

        case (decoded.opcode)
            rv_isa_pkg::op: begin
                rf_write.enable = 1'b1;
                case ({decoded.funct7[5], decoded.funct3})
                    4'b0_000: alu_op = core_pkg::add;
                    4'b1_000: alu_op = core_pkg::sub;
                    4'b0_111: alu_op = core_pkg::and_op;
                    4'b0_110: alu_op = core_pkg::or_op;
                    4'b0_100: alu_op = core_pkg::xor_op;
                    4'b0_001: alu_op = core_pkg::sll;
                    4'b0_101: alu_op = core_pkg::srl;
                    4'b1_101: alu_op = core_pkg::sra;
                    4'b0_010: alu_op = core_pkg::slt;
                    4'b0_011: alu_op = core_pkg::sltu;
                    default:  rf_write.enable = 1'b0; // Reserved pairing
                endcase
            end
            rv_isa_pkg::op_imm: begin
                rf_write.enable = 1'b1;
                alu_b           = decoded.imm;
                case (decoded.funct3)
                    3'b000: alu_op = core_pkg::add;
                    3'b010: alu_op = core_pkg::slt;
                    3'b011: alu_op = core_pkg::sltu;
                    3'b100: alu_op = core_pkg::xor_op;
                    3'b110: alu_op = core_pkg::or_op;
                    3'b111: alu_op = core_pkg::and_op;
                    3'b001: begin
                        alu_op = core_pkg::sll;
                        alu_b  = core_pkg::word_t'(decoded.shamt);
                    end
                    3'b101: begin
                        alu_op = decoded.funct7[5] ? core_pkg::sra : core_pkg::srl;
                        alu_b  = core_pkg::word_t'(decoded.shamt);
                    end
                endcase
            end
            rv_isa_pkg::lui: begin
                rf_write.enable = 1'b1;
                alu_op          = core_pkg::pass_b;
                alu_b           = decoded.imm;
            end
            rv_isa_pkg::auipc: begin
                rf_write.enable = 1'b1;
                alu_a           = pc;
                alu_b           = decoded.imm;
            end
            rv_isa_pkg::jal: begin
                rf_write.enable = 1'b1;
                rf_write.data   = link_addr;
                alu_a           = pc; // ALU forms the jump target
                alu_b           = decoded.imm;
            end
            rv_isa_pkg::jalr: begin
                rf_write.enable = 1'b1;
                rf_write.data   = link_addr;
                alu_b           = decoded.imm;
            end
            rv_isa_pkg::branch: begin
                alu_a          = pc; // Target is pc plus the B immediate
                alu_b          = decoded.imm;
                probe.br_taken = branch_cond;
            end
            default: ; // Loads, stores and unknown encodings write nothing
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
module register_file (
    input  logic                                  clock,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] rs2_addr,
    input  core_pkg::rf_write_t                   write,
    output core_pkg::word_t                       rs1_data,
    output core_pkg::word_t                       rs2_data
);

    localparam int num_regs = 2 ** rv_isa_pkg::reg_addr_width;

    core_pkg::word_t regs [num_regs];

    // Entry zero is never written
    always_ff @(posedge clock) begin
        if (write.enable && write.dest != '0) begin
            regs[write.dest] <= write.data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_core.sv ====
module rv_core (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::word_t       insn,
    output core_pkg::word_t       pc,
    output core_pkg::exec_probe_t probe
);

    rv_isa_pkg::decoded_insn_t decoded;
    core_pkg::word_t           rs1_data;
    core_pkg::word_t           rs2_data;
    core_pkg::alu_op_e         alu_op;
    core_pkg::word_t           alu_a;
    core_pkg::word_t           alu_b;
    core_pkg::word_t           alu_result;
    core_pkg::rf_write_t       rf_write;

    // Fetch always steps by one word, jumps and branches are reported only
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= core_pkg::reset_pc;
        end else begin
            pc <= pc + core_pkg::pc_step;
        end
    end

    insn_decode u_decode (
        .insn    (insn),
        .decoded (decoded)
    );

    register_file u_regfile (
        .clock    (clock),
        .rs1_addr (decoded.rs1),
        .rs2_addr (decoded.rs2),
        .write    (rf_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_control u_exec (
        .decoded    (decoded),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .rf_write   (rf_write),
        .probe      (probe)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

endmodule

// ==== verif/rv_core_asserts.sv ====
module rv_core_asserts (
    input logic                  clock,
    input logic                  reset,
    input core_pkg::word_t       insn,
    input core_pkg::word_t       pc,
    input core_pkg::exec_probe_t probe
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0; // Watched by the testbench

    pc_after_reset: assert property (@(posedge clock) reset |=> pc == core_pkg::reset_pc)
        else begin
            fail_count++;
            $error("pc did not load the reset address after reset");
        end

    // Jumps and branches never redirect fetch
    pc_advance: assert property (@(posedge clock)
        !reset |=> pc == $past(pc) + core_pkg::pc_step)
        else begin
            fail_count++;
            $error("pc did not advance by one instruction word");
        end

    taken_only_on_branch: assert property (@(posedge clock) disable iff (reset)
        (insn[6:0] != rv_isa_pkg::branch) |-> !probe.br_taken)
        else begin
            fail_count++;
            $error("br_taken set for an instruction that is not a branch");
        end

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clock (clock),
    .reset (reset),
    .insn  (insn),
    .pc    (pc),
    .probe (probe)
);

// ==== verif/tb_rv_core.sv ====
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period  = 100; // ns
    localparam int drive_delay   = 1;   // ns after the rising edge
    localparam int reset_cycles  = 4;
    localparam int num_steps     = 43;  // Instruction lines in the golden file
    localparam int cols          = 4;   // insn, pc, alu_res, br_taken
    localparam int pc_step_bytes = 4;
    localparam core_pkg::word_t nop_insn = 32'h0000_0013; // addi x0, x0, 0

    logic                  clock;
    logic                  reset;
    core_pkg::word_t       insn;
    core_pkg::word_t       pc;
    core_pkg::exec_probe_t probe;

    core_pkg::word_t golden [num_steps*cols];

    rv_core DUT (
        .clock (clock),
        .reset (reset),
        .insn  (insn),
        .pc    (pc),
        .probe (probe)
    );

    always #(clock_period/2) clock = ~clock;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_word(
        input core_pkg::word_t expected,
        input core_pkg::word_t actual,
        input string           name
    );
        if (actual !== expected) begin
            stop_run($sformatf("[ERROR] %0t ns %s expected %h actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_taken(
        input logic  expected,
        input logic  actual,
        input string name
    );
        if (actual !== expected) begin
            stop_run($sformatf("[ERROR] %0t ns %s expected %b actual %b",
                               $time, name, expected, actual));
        end
    endtask

    // Plays instruction memory for one cycle and checks mid-cycle
    task automatic run_step(input int step);
        core_pkg::word_t exp_pc;
        core_pkg::word_t exp_res;
        logic            exp_taken;
        exp_pc    = golden[step*cols+1];
        exp_res   = golden[step*cols+2];
        exp_taken = golden[step*cols+3][0];
        insn      = golden[step*cols];
        @(negedge clock); // Combinational path settled
        check_word(exp_pc, pc, "pc");
        check_word(exp_pc, probe.pc, "probe.pc");
        check_word(exp_res, probe.alu_res, "probe.alu_res");
        check_taken(exp_taken, probe.br_taken, "probe.br_taken");
        @(posedge clock);
        #(drive_delay);
    endtask

    initial begin
        core_pkg::word_t last_pc;
        clock = 1'b0;
        reset = 1'b1;
        insn  = nop_insn; // Harmless write to x0 while in reset
        $readmemh("verif/rv_core_golden.txt", golden);
        last_pc = core_pkg::reset_pc + core_pkg::word_t'((num_steps - 1) * pc_step_bytes);
        if (golden[(num_steps-1)*cols+1] !== last_pc) begin
            stop_run("Golden file is missing or shorter than the expected step count");
        end
        repeat (reset_cycles) @(posedge clock);
        #(drive_delay);
        reset = 1'b0;
        for (int i = 0; i < num_steps; i++) begin
            run_step(i);
        end
        insn = nop_insn;
        $display("Result: PASSED");
        $finish;
    end

    // First failing bound assertion ends the run
    always @(DUT.u_asserts.fail_count) begin
        if (DUT.u_asserts.fail_count != 0) begin
            stop_run("A bound assertion on the core failed");
        end
    end

    // Watchdog sized from the program length plus reset and some slack
    initial begin
        #((num_steps + reset_cycles + 10) * clock_period);
        stop_run("Watchdog expired before the instruction sequence finished");
    end

endmodule

// ==== verif/rv_core_golden.txt ====
// One step per line: insn, expected pc, expected alu_res, expected br_taken (hex)
// Registers: x1=80000000 x2=fffffffb x3=0000000c after the first three steps
800000B7 01000000 80000000 0
FFB00113 01000004 FFFFFFFB 0
00C00193 01000008 0000000C 0
0F017213 0100000C 000000F0 0
F001E293 01000010 FFFFFF0C 0
0051C313 01000014 00000009 0
FFC12393 01000018 00000001 0
FFF1B413 0100001C 00000001 0
4040D493 01000020 F8000000 0
0040D513 01000024 08000000 0
01C19593 01000028 C0000000 0
00310633 0100002C 00000007 0
403106B3 01000030 FFFFFFEF 0
0022F733 01000034 FFFFFF08 0
006267B3 01000038 000000F9 0
0042C833 0100003C FFFFFFFC 0
006198B3 01000040 00001800 0
0030D933 01000044 00080000 0
4030D9B3 01000048 FFF80000 0
00312A33 0100004C 00000001 0
00313AB3 01000050 00000000 0
12345B17 01000054 13345054 0
01000BEF 01000058 01000068 0
FFC18C67 0100005C 00000008 0
000B8CB3 01000060 0100005C 0
000C0D33 01000064 01000060 0
00318463 01000068 01000070 1
FE3108E3 0100006C 0100005C 0
00311463 01000070 01000078 1
FE3198E3 01000074 01000064 0
00314463 01000078 01000080 1
FE21C8E3 0100007C 0100006C 0
0021D463 01000080 01000088 1
FE3158E3 01000084 01000074 0
0021E463 01000088 01000090 1
FE3168E3 0100008C 0100007C 0
00317463 01000090 01000098 1
FE21F8E3 01000094 01000084 0
00718013 01000098 00000013 0
00000DB3 0100009C 00000000 0
00312423 010000A0 00000007 0
00412183 010000A4 FFFFFFFB 0
00018E33 010000A8 0000000C 0

// ==== sources.f ====
common/rv_isa_pkg.sv
common/core_pkg.sv
decode/insn_decode.sv
execute/alu.sv
execute/exec_control.sv
hw/register_file.sv
hw/rv_core.sv
verif/rv_core_asserts.sv
verif/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_isa_pkg.sv
  - common/core_pkg.sv
  - decode/insn_decode.sv
  - execute/alu.sv
  - execute/exec_control.sv
  - hw/register_file.sv
  - hw/rv_core.sv
  - target: test
    files:
      - verif/rv_core_asserts.sv
      - verif/tb_rv_core.sv
